// File: cmd_fifo.sv
`timescale 1ns/1ps

// Command buffer in front of the SPI master
// Host is paced by credits, so a push is never refused
module cmd_fifo
   import emesh_spi_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
) (
   input  logic       clk,
   input  logic       rst,
   input  logic       push,
   input  emesh_pkt_t push_pkt,
   input  logic       pop,
   output logic       valid,
   output emesh_pkt_t head_pkt,
   output logic       credit
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int OCC_W = $clog2(FIFO_DEPTH + 1);

   emesh_pkt_t       mem [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [OCC_W-1:0] count;
   logic             pop_ok;

   // Show-ahead head entry
   assign valid    = (count != '0);
   assign head_pkt = mem[rd_ptr];
   assign pop_ok   = pop && valid;

   // Storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_pkt;
      end
   end

   // Pointers, occupancy and credit return
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         // One credit back per entry released
         credit <= pop_ok;
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: emesh_spi_pkg.sv
// Shared widths, frame layout and packet types for the emesh SPI link
package emesh_spi_pkg;

   // ##########################################################################
   // Widths
   // ##########################################################################

   // Word address into the register memory
   localparam int AW = 7;

   // Data word
   localparam int DW = 32;

   // Header is the write bit followed by the address
   localparam int HDR_W = 1 + AW;

   // Full frame, header then data, MSB first
   localparam int FRAME_W = HDR_W + DW;

   // Counts bits 0..FRAME_W inside a frame
   localparam int BIT_CNT_W = $clog2(FRAME_W + 1);

   // ##########################################################################
   // Packets
   // ##########################################################################

   // Host command, laid out in frame order so it loads straight into
   // the transmit shift register
   typedef struct packed {
      logic          write;
      logic [AW-1:0] addr;
      logic [DW-1:0] data;
   } emesh_pkt_t;

   // Read response back to the host
   typedef struct packed {
      logic [AW-1:0] addr;
      logic [DW-1:0] data;
   } rsp_pkt_t;

endpackage

// File: emesh_spi_properties.sv
`timescale 1ns/1ps

// Protocol checks on the top level bound into emesh_spi_top
module emesh_spi_properties
   import emesh_spi_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
) (
   input logic          clk,
   input logic          rst,
   input logic          cmd_valid,
   input logic          credit,
   input logic          access_out,
   input logic [AW-1:0] rsp_addr,
   input logic [DW-1:0] rsp_data,
   input logic          wait_in,
   input logic          sclk,
   input logic          ss_n
);

   // Host view of the credit count
   int credits;
   int fail_cnt = 0;

   always_ff @(posedge clk) begin
      if (rst) begin
         credits <= FIFO_DEPTH;
      end else begin
         credits <= credits - int'(cmd_valid) + int'(credit);
      end
   end

   // A send always spends a credit that is there
   credit_ok: assert property (@(posedge clk) disable iff (rst)
      cmd_valid |-> credits > 0)
   else begin
      $error("command sent with no credit left");
      fail_cnt++;
   end

   // Held response must not move
   rsp_stable: assert property (@(posedge clk) disable iff (rst)
      access_out && wait_in |=> access_out && $stable(rsp_addr) && $stable(rsp_data))
   else begin
      $error("response changed while wait_in was high");
      fail_cnt++;
   end

   // Deselected link keeps sclk low
   link_idle: assert property (@(posedge clk) disable iff (rst)
      ss_n |-> !sclk)
   else begin
      $error("sclk high while ss_n is high");
      fail_cnt++;
   end

   // No frame runs while a response is offered
   rsp_no_frame: assert property (@(posedge clk) disable iff (rst)
      access_out |-> ss_n)
   else begin
      $error("frame active while a response is pending");
      fail_cnt++;
   end

   // Outputs quiet out of reset
   reset_quiet: assert property (@(posedge clk)
      rst |=> !credit && !access_out && ss_n && !sclk)
   else begin
      $error("outputs not idle during reset");
      fail_cnt++;
   end

endmodule

bind emesh_spi_top emesh_spi_properties #(.FIFO_DEPTH(FIFO_DEPTH)) props_i (
   .clk        (clk),
   .rst        (rst),
   .cmd_valid  (cmd_valid),
   .credit     (credit),
   .access_out (access_out),
   .rsp_addr   (rsp_addr),
   .rsp_data   (rsp_data),
   .wait_in    (wait_in),
   .sclk       (spi_bus.sclk),
   .ss_n       (spi_bus.ss_n)
);

// File: emesh_spi_top.sv
`timescale 1ns/1ps

// Emesh over SPI
// Drive through the master, decode on the slave, memory behind the slave
module emesh_spi_top
   import emesh_spi_pkg::*;
#(
   parameter int FIFO_DEPTH = 4,
   parameter int CLK_DIV    = 2
) (
   input  logic          clk,
   input  logic          rst,
   // Command side, credit paced
   input  logic          cmd_valid,
   input  logic          cmd_write,
   input  logic [AW-1:0] cmd_addr,
   input  logic [DW-1:0] cmd_data,
   output logic          credit,
   // Response side, wait back-pressure
   output logic          access_out,
   output logic [AW-1:0] rsp_addr,
   output logic [DW-1:0] rsp_data,
   input  logic          wait_in
);

   emesh_pkt_t    cmd_pkt;
   emesh_pkt_t    fifo_pkt;
   logic          fifo_valid;
   logic          fifo_pop;
   logic          mem_we;
   logic [AW-1:0] mem_addr;
   logic [DW-1:0] mem_wdata;
   logic [DW-1:0] mem_rdata;

   spi_if spi_bus ();

   // Command fields in frame order
   assign cmd_pkt = '{write: cmd_write, addr: cmd_addr, data: cmd_data};

   cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) cmd_fifo_i (
      .clk      (clk),
      .rst      (rst),
      .push     (cmd_valid),
      .push_pkt (cmd_pkt),
      .pop      (fifo_pop),
      .valid    (fifo_valid),
      .head_pkt (fifo_pkt),
      .credit   (credit)
   );

   spi_master #(.CLK_DIV(CLK_DIV)) spi_master_i (
      .clk        (clk),
      .rst        (rst),
      .fifo_valid (fifo_valid),
      .fifo_pkt   (fifo_pkt),
      .fifo_pop   (fifo_pop),
      .access_out (access_out),
      .rsp_addr   (rsp_addr),
      .rsp_data   (rsp_data),
      .wait_in    (wait_in),
      .spi        (spi_bus.master)
   );

   spi_slave spi_slave_i (
      .clk       (clk),
      .rst       (rst),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata),
      .spi       (spi_bus.slave)
   );

   reg_mem reg_mem_i (
      .clk   (clk),
      .rst   (rst),
      .we    (mem_we),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .rdata (mem_rdata)
   );

endmodule

// File: reg_mem.sv
`timescale 1ns/1ps

// Word register memory behind the slave
// Write on the clk edge, read straight from the array
module reg_mem
   import emesh_spi_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  logic          we,
   input  logic [AW-1:0] addr,
   input  logic [DW-1:0] wdata,
   output logic [DW-1:0] rdata
);

   localparam int WORDS = 2 ** AW;

   logic [DW-1:0] mem [WORDS];

   // ##########################################################################
   // Write port
   // ##########################################################################

   // Every word reads as zero after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[addr] <= wdata;
      end
   end

   // ##########################################################################
   // Read port
   // ##########################################################################

   // Slave latches this at the header boundary
   assign rdata = mem[addr];

endmodule

// File: run.sh
#!/bin/sh
# Build and run the emesh SPI testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_emesh_spi -o sim_tb

# Keep running past assertion errors so the testbench prints its verdict
./obj_dir/sim_tb +verilator+error+limit+1000 | tee /dev/stderr \
   | grep -F '*** PASSED ***' > /dev/null

// File: spi_if.sv
`timescale 1ns/1ps

// Serial link between master and slave
// Mode 0, ss_n low for a whole frame, MSB first
interface spi_if;

   // Serial clock, idles low
   logic sclk;

   // Master out, changes on sclk fall
   logic mosi;

   // Slave out, read data during the data phase
   logic miso;

   // Active low select, one slave only
   logic ss_n;

   modport master (
      output sclk,
      output mosi,
      output ss_n,
      input  miso
   );

   modport slave (
      input  sclk,
      input  mosi,
      input  ss_n,
      output miso
   );

endinterface

// File: spi_master.sv
`timescale 1ns/1ps

// SPI master
// Pulls commands from the buffer, sends one 40-bit frame each and
// returns read data as a response held under wait_in
module spi_master
   import emesh_spi_pkg::*;
#(
   parameter int CLK_DIV = 2
) (
   input  logic          clk,
   input  logic          rst,
   input  logic          fifo_valid,
   input  emesh_pkt_t    fifo_pkt,
   output logic          fifo_pop,
   output logic          access_out,
   output logic [AW-1:0] rsp_addr,
   output logic [DW-1:0] rsp_data,
   input  logic          wait_in,
   spi_if.master         spi
);

   localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SETUP,
      ST_SHIFT,
      ST_HOLD,
      ST_RESPOND
   } state_t;

   state_t               state;
   logic [DIV_W-1:0]     div_cnt;
   logic                 half_done;
   logic [BIT_CNT_W-1:0] bit_cnt;
   logic                 sclk_q;
   logic                 ss_n_q;
   logic                 sclk_fall;
   logic [FRAME_W-1:0]   tx_sr;
   logic [DW-1:0]        rx_data;
   logic                 frame_rd;
   logic [AW-1:0]        frame_addr;
   rsp_pkt_t             rsp_q;

   // ##########################################################################
   // Control
   // ##########################################################################

   // Start only when idle and nothing waits on the response port
   assign fifo_pop  = (state == ST_IDLE) && fifo_valid && !access_out;
   assign half_done = (div_cnt == DIV_W'(CLK_DIV - 1));
   // End of a high phase
   assign sclk_fall = (state == ST_SHIFT) && half_done && sclk_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= ST_IDLE;
         div_cnt    <= '0;
         bit_cnt    <= '0;
         sclk_q     <= 1'b0;
         ss_n_q     <= 1'b1;
         access_out <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (fifo_pop) begin
                  ss_n_q  <= 1'b0;
                  div_cnt <= '0;
                  bit_cnt <= '0;
                  state   <= ST_SETUP;
               end
            end
            // One cycle of select before the first edge
            ST_SETUP: state <= ST_SHIFT;
            ST_SHIFT: begin
               if (half_done) begin
                  div_cnt <= '0;
                  sclk_q  <= ~sclk_q;
                  if (sclk_fall && bit_cnt == BIT_CNT_W'(FRAME_W - 1)) begin
                     state <= ST_HOLD;
                  end else if (sclk_fall) begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end else begin
                  div_cnt <= div_cnt + 1'b1;
               end
            end
            // Writes finish here, reads go on to the response port
            ST_HOLD: begin
               ss_n_q <= 1'b1;
               state  <= frame_rd ? ST_RESPOND : ST_IDLE;
            end
            ST_RESPOND: begin
               if (!access_out) begin
                  access_out <= 1'b1;
               end else if (!wait_in) begin
                  access_out <= 1'b0;
                  state      <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // ##########################################################################
   // Datapath
   // ##########################################################################

   always_ff @(posedge clk) begin
      if (fifo_pop) begin
         tx_sr      <= fifo_pkt;
         frame_rd   <= !fifo_pkt.write;
         frame_addr <= fifo_pkt.addr;
      end else if (sclk_fall) begin
         tx_sr <= {tx_sr[FRAME_W-2:0], 1'b0};
         // Slave miso lags by its synchronizer, so sample late in the high phase
         if (bit_cnt >= BIT_CNT_W'(HDR_W)) begin
            rx_data <= {rx_data[DW-2:0], spi.miso};
         end
      end
      // Response loads once and is held until accepted
      if (state == ST_HOLD && frame_rd) begin
         rsp_q.addr <= frame_addr;
         rsp_q.data <= rx_data;
      end
   end

   assign spi.sclk = sclk_q;
   assign spi.mosi = tx_sr[FRAME_W-1];
   assign spi.ss_n = ss_n_q;
   assign rsp_addr = rsp_q.addr;
   assign rsp_data = rsp_q.data;

endmodule

// File: spi_slave.sv
`timescale 1ns/1ps

// SPI slave
// Oversamples the link in the clk domain, decodes the header and
// reads or writes one memory word per frame
module spi_slave
   import emesh_spi_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   output logic          mem_we,
   output logic [AW-1:0] mem_addr,
   output logic [DW-1:0] mem_wdata,
   input  logic [DW-1:0] mem_rdata,
   spi_if.slave          spi
);

   logic [2:0]           sclk_sync;
   logic [1:0]           mosi_sync;
   logic [1:0]           ss_sync;
   logic                 sclk_rise;
   logic                 sclk_fall;
   logic                 mosi_s;
   logic                 ss_n_s;
   logic [BIT_CNT_W-1:0] bit_cnt;
   logic [HDR_W-1:0]     hdr_q;
   logic [DW-1:0]        rx_sr;
   logic [DW-1:0]        miso_sr;

   // ##########################################################################
   // Synchronizers
   // ##########################################################################

   // Idle link values out of reset
   always_ff @(posedge clk) begin
      if (rst) begin
         sclk_sync <= '0;
         ss_sync   <= '1;
      end else begin
         sclk_sync <= {sclk_sync[1:0], spi.sclk};
         ss_sync   <= {ss_sync[0], spi.ss_n};
      end
   end

   // Same depth as sclk so data stays aligned to the edges
   always_ff @(posedge clk) begin
      mosi_sync <= {mosi_sync[0], spi.mosi};
   end

   assign sclk_rise = sclk_sync[1] && !sclk_sync[2];
   assign sclk_fall = !sclk_sync[1] && sclk_sync[2];
   assign mosi_s    = mosi_sync[1];
   assign ss_n_s    = ss_sync[1];

   // ##########################################################################
   // Frame decode
   // ##########################################################################

   // Bit count, cleared between frames
   always_ff @(posedge clk) begin
      if (rst) begin
         bit_cnt <= '0;
         mem_we  <= 1'b0;
      end else begin
         mem_we <= 1'b0;
         if (ss_n_s) begin
            bit_cnt <= '0;
         end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            // Commit after the last bit of a write frame
            if (bit_cnt == BIT_CNT_W'(FRAME_W - 1) && hdr_q[HDR_W-1]) begin
               mem_we <= 1'b1;
            end
         end
      end
   end

   // Receive shift, last 32 bits end up as the write data
   always_ff @(posedge clk) begin
      if (sclk_rise && !ss_n_s) begin
         rx_sr <= {rx_sr[DW-2:0], mosi_s};
         if (bit_cnt == BIT_CNT_W'(HDR_W - 1)) begin
            hdr_q <= {rx_sr[HDR_W-2:0], mosi_s};
         end
      end
   end

   // Read data out, loaded right after the header, then one bit per fall
   always_ff @(posedge clk) begin
      if (rst || ss_n_s) begin
         miso_sr <= '0;
      end else if (sclk_fall) begin
         if (bit_cnt == BIT_CNT_W'(HDR_W) && !hdr_q[HDR_W-1]) begin
            miso_sr <= mem_rdata;
         end else begin
            miso_sr <= {miso_sr[DW-2:0], 1'b0};
         end
      end
   end

   assign mem_addr  = hdr_q[AW-1:0];
   assign mem_wdata = rx_sr;
   assign spi.miso  = miso_sr[DW-1];

endmodule

// File: tb.f
emesh_spi_pkg.sv
spi_if.sv
cmd_fifo.sv
spi_master.sv
spi_slave.sv
reg_mem.sv
emesh_spi_top.sv
emesh_spi_properties.sv
tb_emesh_spi.sv

// File: tb_emesh_spi.sv
`timescale 1ns/1ps

module tb_emesh_spi
   import emesh_spi_pkg::*;
();

   localparam int FIFO_DEPTH = 4;
   localparam int CLK_DIV    = 2;
   // Cycles allowed for any single wait
   localparam int WAIT_LIMIT = 5000;

   logic          clk;
   logic          rst;
   logic          cmd_valid;
   logic          cmd_write;
   logic [AW-1:0] cmd_addr;
   logic [DW-1:0] cmd_data;
   logic          credit;
   logic          access_out;
   logic [AW-1:0] rsp_addr;
   logic [DW-1:0] rsp_data;
   logic          wait_in;

   int            credits;
   int            credit_pulses;
   int            err_cnt;
   int            tests_run;
   int            tests_failed;
   int            seed;
   bit            timed_out;
   logic [DW-1:0] model_mem [2**AW];
   rsp_pkt_t      exp_q [$];

   emesh_spi_top #(.FIFO_DEPTH(FIFO_DEPTH), .CLK_DIV(CLK_DIV)) dut_i (
      .clk        (clk),
      .rst        (rst),
      .cmd_valid  (cmd_valid),
      .cmd_write  (cmd_write),
      .cmd_addr   (cmd_addr),
      .cmd_data   (cmd_data),
      .credit     (credit),
      .access_out (access_out),
      .rsp_addr   (rsp_addr),
      .rsp_data   (rsp_data),
      .wait_in    (wait_in)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ##########################################################################
   // Checks and bookkeeping
   // ##########################################################################

   function automatic int total_errs();
      return err_cnt + dut_i.props_i.fail_cnt;
   endfunction

   task automatic check_value(input string name, input logic [DW-1:0] act,
                              input logic [DW-1:0] exp);
      assert (act === exp) else begin
         $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic note_timeout(input string what);
      $display("timeout at %0t: %s", $time, what);
      timed_out = 1'b1;
   endtask

   task automatic end_test(input string name, input int errs_before);
      tests_run++;
      if (timed_out || total_errs() != errs_before) begin
         tests_failed++;
         $display("test %s: fail", name);
      end else begin
         $display("test %s: ok", name);
      end
   endtask

   // Credit and response are stable at the falling edge
   always @(negedge clk) begin
      rsp_pkt_t exp_rsp;
      if (!rst) begin
         if (credit) begin
            credits++;
            credit_pulses++;
         end
         // Transfer happens at the next edge
         if (access_out && !wait_in) begin
            if (exp_q.size() == 0) begin
               $display("response at %0t with no read outstanding", $time);
               err_cnt++;
            end else begin
               exp_rsp = exp_q.pop_front();
               check_value("rsp_addr", DW'(rsp_addr), DW'(exp_rsp.addr));
               check_value("rsp_data", rsp_data, exp_rsp.data);
            end
         end
      end
   end

   // ##########################################################################
   // Host side
   // ##########################################################################

   // At most one command per cycle and only with a credit in hand
   task automatic send_cmd(input logic wr, input logic [AW-1:0] addr,
                           input logic [DW-1:0] data);
      int n;
      n = 0;
      if (timed_out) return;
      @(posedge clk);
      #2;
      cmd_valid = 1'b0;
      while (credits == 0 && n < WAIT_LIMIT) begin
         @(posedge clk);
         #2;
         n++;
      end
      if (credits == 0) begin
         note_timeout("no credit came back for the next command");
      end else begin
         cmd_valid = 1'b1;
         cmd_write = wr;
         cmd_addr  = addr;
         cmd_data  = data;
         credits--;
         // Commands run in order, so the model is updated at issue
         if (wr) begin
            model_mem[addr] = data;
         end else begin
            exp_q.push_back('{addr: addr, data: model_mem[addr]});
         end
      end
   endtask

   task automatic idle_bus();
      @(posedge clk);
      #2;
      cmd_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (!timed_out && exp_q.size() != 0 && n < WAIT_LIMIT) begin
         @(posedge clk);
         #2;
         n++;
      end
      if (!timed_out && exp_q.size() != 0) note_timeout("read responses did not arrive");
   endtask

   task automatic wait_access();
      int n;
      n = 0;
      while (!timed_out && !access_out && n < WAIT_LIMIT) begin
         @(posedge clk);
         #2;
         n++;
      end
      if (!timed_out && !access_out) note_timeout("access_out never rose");
   endtask

   task automatic wait_credits_full();
      int n;
      n = 0;
      while (!timed_out && credits != FIFO_DEPTH && n < WAIT_LIMIT) begin
         @(posedge clk);
         #2;
         n++;
      end
      if (!timed_out && credits != FIFO_DEPTH) note_timeout("credits did not all return");
   endtask

   // ##########################################################################
   // Tests
   // ##########################################################################

   initial begin
      int            errs;
      int            held_cnt;
      logic          wr;
      logic [AW-1:0] addr;
      rst           = 1'b1;
      cmd_valid     = 1'b0;
      cmd_write     = 1'b0;
      cmd_addr      = '0;
      cmd_data      = '0;
      wait_in       = 1'b0;
      credits       = FIFO_DEPTH;
      credit_pulses = 0;
      err_cnt       = 0;
      tests_run     = 0;
      tests_failed  = 0;
      seed          = 46;
      timed_out     = 1'b0;
      for (int i = 0; i < 2**AW; i++) begin
         model_mem[i] = '0;
      end
      repeat (8) @(posedge clk);
      #2;
      rst = 1'b0;

      // Untouched word reads back zero
      errs = total_errs();
      send_cmd(1'b0, 7'h55, '0);
      idle_bus();
      wait_drain();
      end_test("read_unwritten", errs);

      errs = total_errs();
      send_cmd(1'b1, 7'h10, 32'hcafe_0123);
      send_cmd(1'b0, 7'h10, '0);
      idle_bus();
      wait_drain();
      end_test("write_read", errs);

      // Back-to-back commands return every credit
      errs = total_errs();
      credit_pulses = 0;
      send_cmd(1'b1, 7'h20, 32'h1111_2222);
      send_cmd(1'b1, 7'h21, 32'h3333_4444);
      send_cmd(1'b0, 7'h20, '0);
      send_cmd(1'b0, 7'h21, '0);
      idle_bus();
      wait_credits_full();
      wait_drain();
      check_value("credit_pulses", DW'(credit_pulses), DW'(FIFO_DEPTH));
      end_test("credits", errs);

      // First response parked under wait_in while the rest queue behind it
      errs = total_errs();
      wait_in = 1'b1;
      send_cmd(1'b0, 7'h21, '0);
      send_cmd(1'b0, 7'h10, '0);
      send_cmd(1'b0, 7'h20, '0);
      idle_bus();
      wait_access();
      // Held response blocks new frames, so no credit comes back
      held_cnt = credit_pulses;
      repeat (200) @(posedge clk);
      #2;
      check_value("credit_pulses", DW'(credit_pulses), DW'(held_cnt));
      check_value("access_out", DW'(access_out), DW'(1));
      wait_in = 1'b0;
      wait_drain();
      end_test("wait_hold", errs);

      // Mixed traffic over a handful of words
      errs = total_errs();
      repeat (40) begin
         wr   = 1'($random(seed));
         addr = AW'($unsigned($random(seed)) % 4);
         send_cmd(wr, addr, $random(seed));
      end
      idle_bus();
      wait_drain();
      end_test("random", errs);

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs());
      if (tests_failed == 0 && total_errs() == 0 && !timed_out) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
